// ==== buffer_write_if.sv ====
`include "capi_defs.svh"

// One buffer-write strobe from the host side
interface buffer_write_if;

  logic                       valid;       // Single-cycle strobe
  logic [0:`CAPI_TAG_BITS-1]  tag;
  logic                       tag_parity;
  logic [0:`CAPI_ADDR_BITS-1] address;
  logic [0:`CAPI_DATA_BITS-1] data;
  logic [0:`CAPI_PAR_BITS-1]  parity;      // Bit i covers doubleword i

  modport source (
    output valid, tag, tag_parity, address, data, parity
  );

  modport sink (
    input valid, tag, tag_parity, address, data, parity
  );

endinterface

// ==== capi_defs.svh ====
`ifndef CAPI_DEFS_SVH
`define CAPI_DEFS_SVH

////////////////////
// Buffer write widths
////////////////////

// Half cache line payload
`define CAPI_DATA_BITS 512

// One odd parity bit per doubleword
`define CAPI_PAR_BITS 8

// Half-line address within a transfer
`define CAPI_ADDR_BITS 6

////////////////////
// Command tags
////////////////////

`define CAPI_TAG_BITS 8

// Every tag value has its own table entry
`define CAPI_TAGS 256

`endif

// ==== capi_pkg.sv ====
`include "capi_defs.svh"

package capi_pkg;

  ////////////////////
  // Command kinds
  ////////////////////

  typedef enum logic [1:0] {
    CMD_NONE = 2'b00,
    CMD_READ = 2'b01,  // Plain data read
    CMD_WED  = 2'b10   // Work element descriptor fetch
  } cmd_type_e;

  ////////////////////
  // Lookup and check results
  ////////////////////

  // Command found behind an incoming tag
  typedef struct packed {
    logic [0:`CAPI_TAG_BITS-1] tag;
    cmd_type_e                 cmd_type;
    logic                      known;     // Entry written since reset
  } cmd_line_t;

  // Outcome of the parity checks for one strobe
  typedef struct packed {
    logic checked;     // One-cycle strobe
    logic tag_error;
    logic data_error;  // Any doubleword mismatch
  } parity_result_t;

endpackage

// ==== files.f ====
+incdir+.
capi_pkg.sv
buffer_write_if.sv
tag_table.sv
parity_checker.sv
read_data_control.sv
read_buffer_top.sv
read_buffer_tb.sv

// ==== parity_checker.sv ====
`include "capi_defs.svh"

module parity_checker (
  input  logic                   clock,
  input  logic                   rstn,
  input  logic                   enabled,
  buffer_write_if.sink           buffer_write,
  output capi_pkg::parity_result_t result
);

  localparam int DW_BITS = `CAPI_DATA_BITS / `CAPI_PAR_BITS;

  logic                       valid_q;
  logic [0:`CAPI_TAG_BITS-1]  tag_q;
  logic                       tag_parity_q;
  logic [0:`CAPI_DATA_BITS-1] data_q;
  logic [0:`CAPI_PAR_BITS-1]  parity_q;

  logic                       tag_mismatch;
  logic [0:`CAPI_PAR_BITS-1]  dw_mismatch;

  ////////////////////
  // Strobe capture
  ////////////////////

  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= enabled && buffer_write.valid;
    end
  end

  always_ff @(posedge clock) begin
    if (enabled && buffer_write.valid) begin
      tag_q        <= buffer_write.tag;
      tag_parity_q <= buffer_write.tag_parity;
      data_q       <= buffer_write.data;
      parity_q     <= buffer_write.parity;
    end
  end

  ////////////////////
  // Odd parity checks
  ////////////////////

  // Good when covered bits plus parity bit hold an odd count of ones
  assign tag_mismatch = ~(^{tag_q, tag_parity_q});

  for (genvar i = 0; i < `CAPI_PAR_BITS; i++) begin : g_dw
    assign dw_mismatch[i] = ~(^{data_q[i*DW_BITS +: DW_BITS], parity_q[i]});
  end

  ////////////////////
  // Result register
  ////////////////////

  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      result <= '0;
    end else begin
      result.checked    <= valid_q;
      result.tag_error  <= tag_mismatch;
      result.data_error <= |dw_mismatch;  // Any doubleword
    end
  end

endmodule

// ==== read_buffer_tb_model.svh ====
`ifndef READ_BUFFER_TB_MODEL_SVH
`define READ_BUFFER_TB_MODEL_SVH

// One steered output set as seen on the top-level ports
typedef struct packed {
  logic                       valid;
  logic                       read;
  logic                       wed;
  logic [0:`CAPI_TAG_BITS-1]  tag;
  logic [0:`CAPI_DATA_BITS-1] data;
} half_line_t;

typedef struct packed {
  half_line_t half0;
  half_line_t half1;
} line_pair_t;

// Testbench copy of the command table
cmd_type_e model_type  [`CAPI_TAGS];
logic      model_known [`CAPI_TAGS];

////////////////////
// Odd parity
////////////////////

function automatic logic tag_parity_of(input logic [0:`CAPI_TAG_BITS-1] tag);
  int ones;
  ones = 0;
  for (int b = 0; b < `CAPI_TAG_BITS; b++) begin
    if (tag[b]) ones++;
  end
  return (ones % 2 == 0);  // Total count made odd
endfunction

// Bit i covers data bits 64i to 64i+63, bit 0 at the MSB end
function automatic logic [0:`CAPI_PAR_BITS-1] data_parity_vector(
    input logic [0:`CAPI_DATA_BITS-1] data);
  logic [0:`CAPI_PAR_BITS-1] par;
  int                        ones;
  for (int i = 0; i < `CAPI_PAR_BITS; i++) begin
    ones = 0;
    for (int j = 0; j < 64; j++) begin
      if (data[64 * i + j]) ones++;
    end
    par[i] = (ones % 2 == 0);
  end
  return par;
endfunction

////////////////////
// Expected outputs
////////////////////

function automatic line_pair_t expected_lines(input logic [0:`CAPI_TAG_BITS-1] tag,
    input logic [0:`CAPI_ADDR_BITS-1] addr, input logic [0:`CAPI_DATA_BITS-1] data);
  line_pair_t lines;
  half_line_t line;
  line.valid = 1'b1;
  line.read  = model_known[tag] && (model_type[tag] == CMD_READ);
  line.wed   = model_known[tag] && (model_type[tag] == CMD_WED);
  line.tag   = tag;
  line.data  = data;
  lines      = '0;
  if (addr == '0) begin
    lines.half0 = line;
  end else begin
    lines.half1 = line;
  end
  return lines;
endfunction

// Tag error in bit 1, data error in bit 0
function automatic logic [1:0] expected_error(input logic [0:`CAPI_TAG_BITS-1] tag,
    input logic tag_par, input logic [0:`CAPI_DATA_BITS-1] data,
    input logic [0:`CAPI_PAR_BITS-1] par);
  return {tag_par != tag_parity_of(tag), par != data_parity_vector(data)};
endfunction

`endif

// ==== read_buffer_tb.sv ====
`include "capi_defs.svh"

module read_buffer_tb;

  timeunit 1ns;
  timeprecision 1ps;

  import capi_pkg::*;

  `include "read_buffer_tb_model.svh"

  localparam int DRAIN_TIMEOUT = 50;  // Cycles

  typedef struct {
    int         due;
    line_pair_t lines;
  } line_entry_t;

  typedef struct {
    int         due;
    logic [1:0] error;
  } error_entry_t;

  logic                       clock;
  logic                       rstn;
  logic                       enabled;
  logic                       cmd_valid;
  logic [0:`CAPI_TAG_BITS-1]  cmd_tag;
  cmd_type_e                  cmd_type;
  logic                       write_valid;
  logic [0:`CAPI_TAG_BITS-1]  write_tag;
  logic                       write_tag_parity;
  logic [0:`CAPI_ADDR_BITS-1] write_address;
  logic [0:`CAPI_DATA_BITS-1] write_data;
  logic [0:`CAPI_PAR_BITS-1]  write_parity;
  logic                       half0_valid;
  logic                       half0_read;
  logic                       half0_wed;
  logic [0:`CAPI_TAG_BITS-1]  half0_tag;
  logic [0:`CAPI_DATA_BITS-1] half0_data;
  logic                       half1_valid;
  logic                       half1_read;
  logic                       half1_wed;
  logic [0:`CAPI_TAG_BITS-1]  half1_tag;
  logic [0:`CAPI_DATA_BITS-1] half1_data;
  logic [1:0]                 data_read_error;

  int           cycle_count;
  line_entry_t  line_queue[$];
  error_entry_t error_queue[$];

  read_buffer_top UUT (.*);

  always #50 clock = ~clock;

  always @(posedge clock) cycle_count <= cycle_count + 1;

  ////////////////////
  // Failure reports
  ////////////////////

  task automatic report_mismatch(input string name, input logic [511:0] expected,
                                 input logic [511:0] actual);
    $display("FAILED %s expected %0h got %0h at cycle %0d", name, expected, actual,
             cycle_count);
    $display("*** TEST FAILED ***");
    $fatal(1);
  endtask

  task automatic timeout_abort(input string what);
    $display("Timeout after %0d cycles, %s", DRAIN_TIMEOUT, what);
    $display("*** TEST FAILED ***");
    $fatal(1);
  endtask

  ////////////////////
  // Compare
  ////////////////////

  // Outputs are stable at the falling edge before the edge that samples them
  always @(negedge clock) begin : compare_outputs
    line_pair_t   exp_lines;
    logic [1:0]   exp_error;
    int           check_cycle;
    line_entry_t  line_entry;
    error_entry_t error_entry;
    check_cycle = cycle_count + 1;
    exp_lines   = '0;
    exp_error   = 2'b00;
    if (line_queue.size() > 0 && line_queue[0].due == check_cycle) begin
      line_entry = line_queue.pop_front();
      exp_lines  = line_entry.lines;
    end
    if (error_queue.size() > 0 && error_queue[0].due == check_cycle) begin
      error_entry = error_queue.pop_front();
      exp_error   = error_entry.error;
    end
    if (cycle_count >= 1) begin  // Zero from the first reset edge on
      assert (half0_valid === exp_lines.half0.valid)
        else report_mismatch("half0_valid", 512'(exp_lines.half0.valid), 512'(half0_valid));
      assert (half0_read === exp_lines.half0.read)
        else report_mismatch("half0_read", 512'(exp_lines.half0.read), 512'(half0_read));
      assert (half0_wed === exp_lines.half0.wed)
        else report_mismatch("half0_wed", 512'(exp_lines.half0.wed), 512'(half0_wed));
      assert (half0_tag === exp_lines.half0.tag)
        else report_mismatch("half0_tag", 512'(exp_lines.half0.tag), 512'(half0_tag));
      assert (half0_data === exp_lines.half0.data)
        else report_mismatch("half0_data", exp_lines.half0.data, half0_data);
      assert (half1_valid === exp_lines.half1.valid)
        else report_mismatch("half1_valid", 512'(exp_lines.half1.valid), 512'(half1_valid));
      assert (half1_read === exp_lines.half1.read)
        else report_mismatch("half1_read", 512'(exp_lines.half1.read), 512'(half1_read));
      assert (half1_wed === exp_lines.half1.wed)
        else report_mismatch("half1_wed", 512'(exp_lines.half1.wed), 512'(half1_wed));
      assert (half1_tag === exp_lines.half1.tag)
        else report_mismatch("half1_tag", 512'(exp_lines.half1.tag), 512'(half1_tag));
      assert (half1_data === exp_lines.half1.data)
        else report_mismatch("half1_data", exp_lines.half1.data, half1_data);
      assert (data_read_error === exp_error)
        else report_mismatch("data_read_error", 512'(exp_error), 512'(data_read_error));
    end
  end

  ////////////////////
  // Stimulus
  ////////////////////

  function automatic logic [0:`CAPI_DATA_BITS-1] random_data();
    logic [0:`CAPI_DATA_BITS-1] data;
    for (int k = 0; k < `CAPI_DATA_BITS / 32; k++) begin
      data[32 * k +: 32] = $urandom;
    end
    return data;
  endfunction

  task automatic issue_command(input logic [0:`CAPI_TAG_BITS-1] tag, input cmd_type_e kind);
    cmd_valid         = 1'b1;
    cmd_tag           = tag;
    cmd_type          = kind;
    model_type[tag]   = kind;
    model_known[tag]  = 1'b1;
    @(negedge clock);
    cmd_valid = 1'b0;
  endtask

  // One strobe cycle, optional flips of tag parity and one data bit
  task automatic write_strobe(input logic [0:`CAPI_TAG_BITS-1] tag,
      input logic [0:`CAPI_ADDR_BITS-1] addr, input logic flip_tag, input int flip_dw);
    logic [0:`CAPI_DATA_BITS-1] data;
    logic                       tpar;
    logic [0:`CAPI_PAR_BITS-1]  dpar;
    int                         bit_no;
    data = random_data();
    tpar = tag_parity_of(tag);
    dpar = data_parity_vector(data);
    if (flip_tag) begin
      tpar = ~tpar;
    end
    if (flip_dw >= 0) begin
      bit_no       = 64 * flip_dw + int'($urandom_range(63));
      data[bit_no] = ~data[bit_no];
    end
    write_valid      = 1'b1;
    write_tag        = tag;
    write_tag_parity = tpar;
    write_address    = addr;
    write_data       = data;
    write_parity     = dpar;
    if (enabled) begin  // Sampled at the next rising edge
      line_queue.push_back('{cycle_count + 3, expected_lines(tag, addr, data)});
      error_queue.push_back('{cycle_count + 4, expected_error(tag, tpar, data, dpar)});
    end
    @(negedge clock);
  endtask

  task automatic bus_idle();
    write_valid = 1'b0;
    @(negedge clock);
  endtask

  task automatic wait_for_drain();
    int waited;
    waited = 0;
    while (line_queue.size() > 0 || error_queue.size() > 0) begin
      @(negedge clock);
      waited++;
      if (waited > DRAIN_TIMEOUT) begin
        timeout_abort("expected lines or error reports never came due");
      end
    end
    @(negedge clock);
  endtask

  initial begin : main_sequence
    logic [0:`CAPI_TAG_BITS-1] tag_a;
    logic [0:`CAPI_TAG_BITS-1] tag_b;
    logic [0:`CAPI_TAG_BITS-1] tag_c;
    logic [0:`CAPI_TAG_BITS-1] tag_d;
    logic [0:`CAPI_TAG_BITS-1] burst_tag;
    void'($urandom(21));
    clock            = 1'b0;
    rstn             = 1'b0;
    enabled          = 1'b1;
    cmd_valid        = 1'b0;
    cmd_tag          = '0;
    cmd_type         = CMD_NONE;
    write_valid      = 1'b0;
    write_tag        = '0;
    write_tag_parity = 1'b0;
    write_address    = '0;
    write_data       = '0;
    write_parity     = '0;
    cycle_count      = 0;
    for (int t = 0; t < `CAPI_TAGS; t++) begin
      model_known[t] = 1'b0;
      model_type[t]  = CMD_NONE;
    end
    repeat (4) @(posedge clock);
    @(negedge clock);
    rstn = 1'b1;
    @(negedge clock);

    tag_a = 8'($urandom);
    tag_b = tag_a ^ 8'h01;
    tag_c = tag_a ^ 8'h02;
    tag_d = tag_a ^ 8'h80;  // Never issued

    // Read to half 0, then half 1 and alternating back-to-back
    issue_command(tag_a, CMD_READ);
    write_strobe(tag_a, '0, 1'b0, -1);
    bus_idle();
    issue_command(tag_b, CMD_READ);
    write_strobe(tag_b, 6'd9, 1'b0, -1);
    for (int i = 0; i < 8; i++) begin
      write_strobe((i % 2 == 1) ? tag_a : tag_b, (i % 2 == 0) ? 6'd0 : 6'(1 + i), 1'b0, -1);
    end
    bus_idle();
    wait_for_drain();

    // Descriptor fetch and unknown tag
    issue_command(tag_c, CMD_WED);
    write_strobe(tag_c, '0, 1'b0, -1);
    write_strobe(tag_c, 6'd33, 1'b0, -1);
    write_strobe(tag_d, '0, 1'b0, -1);
    write_strobe(tag_d, 6'd1, 1'b0, -1);
    bus_idle();
    wait_for_drain();

    // Parity errors
    write_strobe(tag_a, '0, 1'b1, -1);
    write_strobe(tag_b, 6'd2, 1'b0, 3);
    write_strobe(tag_c, '0, 1'b1, 7);
    write_strobe(tag_a, 6'd4, 1'b0, -1);
    bus_idle();
    wait_for_drain();

    // Strobes ignored while disabled
    enabled = 1'b0;
    write_strobe(tag_a, '0, 1'b1, 0);
    write_strobe(tag_b, 6'd5, 1'b0, -1);
    write_strobe(tag_c, '0, 1'b0, 2);
    repeat (4) bus_idle();
    enabled = 1'b1;
    wait_for_drain();

    // Random burst
    for (int i = 0; i < 24; i++) begin
      case ($urandom_range(4))
        0:       burst_tag = tag_a;
        1:       burst_tag = tag_b;
        2:       burst_tag = tag_c;
        3:       burst_tag = tag_d;
        default: burst_tag = 8'($urandom);
      endcase
      write_strobe(burst_tag, ($urandom_range(1) == 0) ? 6'd0 : 6'($urandom),
                   ($urandom_range(3) == 0),
                   ($urandom_range(3) == 0) ? int'($urandom_range(7)) : -1);
    end
    bus_idle();
    wait_for_drain();

    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule

// ==== read_buffer_top.sv ====
`include "capi_defs.svh"

module read_buffer_top (
  input  logic                       clock,
  input  logic                       rstn,
  input  logic                       enabled,
  // Command issue
  input  logic                       cmd_valid,
  input  logic [0:`CAPI_TAG_BITS-1]  cmd_tag,
  input  capi_pkg::cmd_type_e        cmd_type,
  // Buffer write from the host
  input  logic                       write_valid,
  input  logic [0:`CAPI_TAG_BITS-1]  write_tag,
  input  logic                       write_tag_parity,
  input  logic [0:`CAPI_ADDR_BITS-1] write_address,
  input  logic [0:`CAPI_DATA_BITS-1] write_data,
  input  logic [0:`CAPI_PAR_BITS-1]  write_parity,
  // Steered half lines
  output logic                       half0_valid,
  output logic                       half0_read,
  output logic                       half0_wed,
  output logic [0:`CAPI_TAG_BITS-1]  half0_tag,
  output logic [0:`CAPI_DATA_BITS-1] half0_data,
  output logic                       half1_valid,
  output logic                       half1_read,
  output logic                       half1_wed,
  output logic [0:`CAPI_TAG_BITS-1]  half1_tag,
  output logic [0:`CAPI_DATA_BITS-1] half1_data,
  output logic [1:0]                 data_read_error
);

  import capi_pkg::*;

  cmd_line_t      cmd_line;
  parity_result_t parity_result;

  buffer_write_if buffer_write ();

  assign buffer_write.valid      = write_valid;
  assign buffer_write.tag        = write_tag;
  assign buffer_write.tag_parity = write_tag_parity;
  assign buffer_write.address    = write_address;
  assign buffer_write.data       = write_data;
  assign buffer_write.parity     = write_parity;

  ////////////////////
  // Lookup and parity side by side
  ////////////////////

  tag_table u_tag_table (
    .clock        (clock),
    .rstn         (rstn),
    .cmd_valid    (cmd_valid),
    .cmd_tag      (cmd_tag),
    .cmd_type     (cmd_type),
    .buffer_write (buffer_write.sink),
    .enabled      (enabled),
    .cmd_line     (cmd_line)
  );

  parity_checker u_parity_checker (
    .clock        (clock),
    .rstn         (rstn),
    .enabled      (enabled),
    .buffer_write (buffer_write.sink),
    .result       (parity_result)
  );

  read_data_control u_read_data_control (
    .clock           (clock),
    .rstn            (rstn),
    .enabled         (enabled),
    .buffer_write    (buffer_write.sink),
    .cmd_line        (cmd_line),
    .parity          (parity_result),
    .half0_valid     (half0_valid),
    .half0_read      (half0_read),
    .half0_wed       (half0_wed),
    .half0_tag       (half0_tag),
    .half0_data      (half0_data),
    .half1_valid     (half1_valid),
    .half1_read      (half1_read),
    .half1_wed       (half1_wed),
    .half1_tag       (half1_tag),
    .half1_data      (half1_data),
    .data_read_error (data_read_error)
  );

endmodule

// ==== read_data_control.sv ====
`include "capi_defs.svh"

module read_data_control (
  input  logic                       clock,
  input  logic                       rstn,
  input  logic                       enabled,
  buffer_write_if.sink               buffer_write,
  input  capi_pkg::cmd_line_t        cmd_line,
  input  capi_pkg::parity_result_t   parity,
  output logic                       half0_valid,
  output logic                       half0_read,
  output logic                       half0_wed,
  output logic [0:`CAPI_TAG_BITS-1]  half0_tag,
  output logic [0:`CAPI_DATA_BITS-1] half0_data,
  output logic                       half1_valid,
  output logic                       half1_read,
  output logic                       half1_wed,
  output logic [0:`CAPI_TAG_BITS-1]  half1_tag,
  output logic [0:`CAPI_DATA_BITS-1] half1_data,
  output logic [1:0]                 data_read_error
);

  import capi_pkg::*;

  logic                       wr_valid_q;
  logic [0:`CAPI_ADDR_BITS-1] addr_q;
  logic [0:`CAPI_DATA_BITS-1] data_q;

  logic sel0;
  logic sel1;
  logic is_read;
  logic is_wed;

  ////////////////////
  // Write capture
  ////////////////////

  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      wr_valid_q <= 1'b0;
    end else begin
      wr_valid_q <= enabled && buffer_write.valid;
    end
  end

  always_ff @(posedge clock) begin
    if (enabled && buffer_write.valid) begin
      addr_q <= buffer_write.address;
      data_q <= buffer_write.data;
    end
  end

  ////////////////////
  // Half-line steering
  ////////////////////

  assign sel0 = wr_valid_q && (addr_q == '0);  // First half of the line
  assign sel1 = wr_valid_q && (addr_q != '0);

  // Unknown tags decode to neither kind
  assign is_read = cmd_line.known && (cmd_line.cmd_type == CMD_READ);
  assign is_wed  = cmd_line.known && (cmd_line.cmd_type == CMD_WED);

  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      half0_valid <= 1'b0;
      half0_read  <= 1'b0;
      half0_wed   <= 1'b0;
      half0_tag   <= '0;
      half0_data  <= '0;
      half1_valid <= 1'b0;
      half1_read  <= 1'b0;
      half1_wed   <= 1'b0;
      half1_tag   <= '0;
      half1_data  <= '0;
    end else begin
      half0_valid <= sel0;
      half0_read  <= sel0 && is_read;
      half0_wed   <= sel0 && is_wed;
      half0_tag   <= sel0 ? cmd_line.tag : '0;
      half0_data  <= sel0 ? data_q : '0;
      half1_valid <= sel1;
      half1_read  <= sel1 && is_read;
      half1_wed   <= sel1 && is_wed;
      half1_tag   <= sel1 ? cmd_line.tag : '0;
      half1_data  <= sel1 ? data_q : '0;
    end
  end

  ////////////////////
  // Error report
  ////////////////////

  // Tag error in bit 1, data error in bit 0
  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      data_read_error <= 2'b00;
    end else if (parity.checked) begin
      data_read_error <= {parity.tag_error, parity.data_error};
    end else begin
      data_read_error <= 2'b00;  // One-cycle pulse
    end
  end

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the read buffer testbench with Verilator

LOG=sim.log

verilator --binary --assert --timescale 1ns/1ps -f files.f \
  --top-module read_buffer_tb -o read_buffer_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/read_buffer_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q -F "*** TEST PASSED ***" "$LOG"; then
  echo "Simulation passed"
  exit 0
else
  echo "Pass message not found in $LOG"
  exit 1
fi

// ==== tag_table.sv ====
`include "capi_defs.svh"

module tag_table (
  input  logic                      clock,
  input  logic                      rstn,
  input  logic                      cmd_valid,
  input  logic [0:`CAPI_TAG_BITS-1] cmd_tag,
  input  capi_pkg::cmd_type_e       cmd_type,
  buffer_write_if.sink              buffer_write,
  input  logic                      enabled,
  output capi_pkg::cmd_line_t       cmd_line
);

  import capi_pkg::*;

  cmd_type_e            type_mem [`CAPI_TAGS];
  logic [`CAPI_TAGS-1:0] known_q;

  ////////////////////
  // Command issue
  ////////////////////

  always_ff @(posedge clock) begin
    if (cmd_valid) begin
      type_mem[cmd_tag] <= cmd_type;
    end
  end

  // One known bit per tag
  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      known_q <= '0;
    end else if (cmd_valid) begin
      known_q[cmd_tag] <= 1'b1;
    end
  end

  ////////////////////
  // Lookup per strobe
  ////////////////////

  always_ff @(posedge clock) begin
    if (enabled && buffer_write.valid) begin
      cmd_line.tag      <= buffer_write.tag;
      cmd_line.known    <= known_q[buffer_write.tag];
      cmd_line.cmd_type <= type_mem[buffer_write.tag];  // Only meaningful when known
    end
  end

endmodule
